//--- verilog/la_pkg.sv
`default_nettype none

package la_pkg;

    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 17;

    // major opcodes, inst[31:15]
    localparam logic [OPCODE_W-1:0] ADD_OPCODE  = 17'h00020;
    localparam logic [OPCODE_W-1:0] SUB_OPCODE  = 17'h00022;
    localparam logic [OPCODE_W-1:0] SLT_OPCODE  = 17'h00024;
    localparam logic [OPCODE_W-1:0] SLTU_OPCODE = 17'h00025;
    localparam logic [OPCODE_W-1:0] NOR_OPCODE  = 17'h00028;
    localparam logic [OPCODE_W-1:0] AND_OPCODE  = 17'h00029;
    localparam logic [OPCODE_W-1:0] OR_OPCODE   = 17'h0002a;
    localparam logic [OPCODE_W-1:0] XOR_OPCODE  = 17'h0002b;
    localparam logic [OPCODE_W-1:0] SLL_OPCODE  = 17'h0002e;
    localparam logic [OPCODE_W-1:0] SRL_OPCODE  = 17'h0002f;
    localparam logic [OPCODE_W-1:0] SRA_OPCODE  = 17'h00030;
    localparam logic [OPCODE_W-1:0] SLLI_OPCODE = 17'h00081; // ui5 in inst[14:10]
    localparam logic [OPCODE_W-1:0] SRLI_OPCODE = 17'h00089;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_ADD  = 8'h01,
        ALU_SUB  = 8'h02,
        ALU_AND  = 8'h03,
        ALU_OR   = 8'h04,
        ALU_XOR  = 8'h05,
        ALU_NOR  = 8'h06,
        ALU_SLT  = 8'h07,
        ALU_SLTU = 8'h08,
        ALU_SLL  = 8'h09, // also slli.w
        ALU_SRL  = 8'h0a, // also srli.w
        ALU_SRA  = 8'h0b
    } alu_op_t;

    // result class, room left for later classes
    typedef enum logic [2:0] {
        ALU_SEL_NOP   = 3'b000,
        ALU_SEL_ARITH = 3'b001
    } alu_sel_t;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [31:0]           pc;
        alu_op_t               aluop;
        alu_sel_t              alusel;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg1_read_en;
        logic                  reg2_read_en;
        logic                  use_imm;
        logic [31:0]           imm;
        logic                  reg_write_en;
    } id_ex_t;

    // execute to result stage
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [31:0]           pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write_en;
        logic [31:0]           data;
    } ex_wb_t;

endpackage

`default_nettype wire

//--- verilog/id_3r.sv
`default_nettype none
`timescale 1ns/1ps

module id_3r (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_strobe,
    input  logic [31:0]     pc,
    input  logic [31:0]     inst,
    output la_pkg::id_ex_t  id_ex
);
    import la_pkg::*;

    logic [OPCODE_W-1:0]   opcode;
    logic [REG_ADDR_W-1:0] rk;
    logic [REG_ADDR_W-1:0] rj;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            ui5;
    logic                  legal;
    id_ex_t                id_next;

    assign opcode = inst[31:15];
    assign rk     = inst[14:10];
    assign rj     = inst[9:5];
    assign rd     = inst[4:0];
    assign ui5    = inst[14:10]; // shares the rk slot

    always_comb begin
        id_next         = '0;
        id_next.pc      = pc;
        id_next.rj      = rj;
        id_next.rk      = rk;
        id_next.rd      = rd;
        id_next.aluop   = ALU_NOP;
        id_next.alusel  = ALU_SEL_NOP;

        case (opcode)
            ADD_OPCODE:  id_next.aluop = ALU_ADD;
            SUB_OPCODE:  id_next.aluop = ALU_SUB;
            SLT_OPCODE:  id_next.aluop = ALU_SLT;
            SLTU_OPCODE: id_next.aluop = ALU_SLTU;
            NOR_OPCODE:  id_next.aluop = ALU_NOR;
            AND_OPCODE:  id_next.aluop = ALU_AND;
            OR_OPCODE:   id_next.aluop = ALU_OR;
            XOR_OPCODE:  id_next.aluop = ALU_XOR;
            SLL_OPCODE:  id_next.aluop = ALU_SLL;
            SRL_OPCODE:  id_next.aluop = ALU_SRL;
            SRA_OPCODE:  id_next.aluop = ALU_SRA;
            SLLI_OPCODE: begin
                id_next.aluop   = ALU_SLL;
                id_next.use_imm = 1'b1;
                id_next.imm     = {27'b0, ui5};
            end
            SRLI_OPCODE: begin
                id_next.aluop   = ALU_SRL;
                id_next.use_imm = 1'b1;
                id_next.imm     = {27'b0, ui5};
            end
            default: begin
                id_next.aluop = ALU_NOP;
            end
        endcase

        legal = (id_next.aluop != ALU_NOP);

        if (legal) begin
            id_next.alusel       = ALU_SEL_ARITH;
            id_next.reg1_read_en = 1'b1;
            id_next.reg2_read_en = ~id_next.use_imm; // immediate replaces rk
            id_next.reg_write_en = 1'b1;
        end

        id_next.valid   = inst_strobe & legal;
        id_next.illegal = inst_strobe & ~legal;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_next; // idle cycles load a bubble
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [la_pkg::REG_ADDR_W-1:0] read1_addr,
    input  logic [la_pkg::REG_ADDR_W-1:0] read2_addr,
    output logic [31:0]                   read1_data,
    output logic [31:0]                   read2_data,
    input  logic                          write_en,
    input  logic [la_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [31:0]                   write_data
);
    import la_pkg::*;

    logic [31:0] regs [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_addr != '0) begin // r0 is never written
            regs[write_addr] <= write_data;
        end
    end

    // same-cycle write is not seen until the next cycle
    always_comb begin
        if (read1_addr == '0) begin
            read1_data = '0;
        end else begin
            read1_data = regs[read1_addr];
        end
    end

    always_comb begin
        if (read2_addr == '0) begin
            read2_data = '0;
        end else begin
            read2_data = regs[read2_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_exec.sv
`default_nettype none
`timescale 1ns/1ps

module alu_exec (
    input  la_pkg::id_ex_t                id_ex,
    input  la_pkg::ex_wb_t                ex_wb,
    output logic [la_pkg::REG_ADDR_W-1:0] read1_addr,
    output logic [la_pkg::REG_ADDR_W-1:0] read2_addr,
    input  logic [31:0]                   read1_data,
    input  logic [31:0]                   read2_data,
    output la_pkg::ex_wb_t                ex_next
);
    import la_pkg::*;

    logic        wb_fwd;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  shamt;
    logic [31:0] alu_res;

    assign read1_addr = id_ex.rj;
    assign read2_addr = id_ex.rk;

    // producer one slot ahead is still in the result stage
    assign wb_fwd = ex_wb.valid & ex_wb.reg_write_en & (ex_wb.rd != '0);

    always_comb begin
        if (!id_ex.reg1_read_en) begin
            op1 = '0;
        end else if (wb_fwd && ex_wb.rd == id_ex.rj) begin
            op1 = ex_wb.data;
        end else begin
            op1 = read1_data;
        end
    end

    always_comb begin
        if (id_ex.use_imm) begin
            op2 = id_ex.imm;
        end else if (!id_ex.reg2_read_en) begin
            op2 = '0;
        end else if (wb_fwd && ex_wb.rd == id_ex.rk) begin
            op2 = ex_wb.data;
        end else begin
            op2 = read2_data;
        end
    end

    assign shamt = op2[4:0];

    always_comb begin
        case (id_ex.aluop)
            ALU_ADD:  alu_res = op1 + op2;
            ALU_SUB:  alu_res = op1 - op2;
            ALU_AND:  alu_res = op1 & op2;
            ALU_OR:   alu_res = op1 | op2;
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_NOR:  alu_res = ~(op1 | op2);
            ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU: alu_res = {31'b0, op1 < op2};
            ALU_SLL:  alu_res = op1 << shamt;
            ALU_SRL:  alu_res = op1 >> shamt;
            ALU_SRA:  alu_res = $signed(op1) >>> shamt; // sign fill
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        ex_next              = '0;
        ex_next.valid        = id_ex.valid;
        ex_next.illegal      = id_ex.illegal;
        ex_next.pc           = id_ex.pc;
        ex_next.rd           = id_ex.rd;
        ex_next.reg_write_en = id_ex.reg_write_en;
        if (id_ex.alusel == ALU_SEL_ARITH) begin
            ex_next.data = alu_res;
        end else begin
            ex_next.data = '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wb_result.sv
`default_nettype none
`timescale 1ns/1ps

module wb_result (
    input  logic                          clk,
    input  logic                          rst_n,
    input  la_pkg::ex_wb_t                ex_next,
    output la_pkg::ex_wb_t                ex_wb,
    output logic                          write_en,
    output logic [la_pkg::REG_ADDR_W-1:0] write_addr,
    output logic [31:0]                   write_data,
    output logic                          result_valid,
    output logic                          result_illegal,
    output logic [31:0]                   result_pc,
    output logic [la_pkg::REG_ADDR_W-1:0] result_rd,
    output logic [31:0]                   result_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wb <= '0;
        end else begin
            ex_wb <= ex_next;
        end
    end

    // register file write lands on the next edge
    assign write_en   = ex_wb.valid & ex_wb.reg_write_en;
    assign write_addr = ex_wb.rd;
    assign write_data = ex_wb.data;

    assign result_valid   = ex_wb.valid;
    assign result_illegal = ex_wb.illegal;
    assign result_pc      = ex_wb.pc;
    assign result_rd      = ex_wb.rd;

    always_comb begin
        if (write_en && ex_wb.rd != '0) begin
            result_data = ex_wb.data;
        end else begin
            result_data = '0; // r0 or no write
        end
    end

endmodule

`default_nettype wire

//--- verilog/la_core_3r.sv
`default_nettype none
`timescale 1ns/1ps

module la_core_3r (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_strobe,
    input  logic [31:0]                   pc,
    input  logic [31:0]                   inst,
    output logic                          result_valid,
    output logic                          result_illegal,
    output logic [31:0]                   result_pc,
    output logic [la_pkg::REG_ADDR_W-1:0] result_rd,
    output logic [31:0]                   result_data
);
    import la_pkg::*;

    id_ex_t                id_ex;
    ex_wb_t                ex_next;
    ex_wb_t                ex_wb;
    logic [REG_ADDR_W-1:0] read1_addr;
    logic [REG_ADDR_W-1:0] read2_addr;
    logic [31:0]           read1_data;
    logic [31:0]           read2_data;
    logic                  write_en;
    logic [REG_ADDR_W-1:0] write_addr;
    logic [31:0]           write_data;

    id_3r id_3r_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_strobe (inst_strobe),
        .pc          (pc),
        .inst        (inst),
        .id_ex       (id_ex)
    );

    reg_file reg_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .read1_addr (read1_addr),
        .read2_addr (read2_addr),
        .read1_data (read1_data),
        .read2_data (read2_data),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data)
    );

    alu_exec alu_exec_i (
        .id_ex      (id_ex),
        .ex_wb      (ex_wb), // bypass source
        .read1_addr (read1_addr),
        .read2_addr (read2_addr),
        .read1_data (read1_data),
        .read2_data (read2_data),
        .ex_next    (ex_next)
    );

    wb_result wb_result_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_next        (ex_next),
        .ex_wb          (ex_wb),
        .write_en       (write_en),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .result_valid   (result_valid),
        .result_illegal (result_illegal),
        .result_pc      (result_pc),
        .result_rd      (result_rd),
        .result_data    (result_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_la_core_3r.sv
`default_nettype none
`timescale 1ns/1ps

module tb_la_core_3r;
    import la_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int IDLE_CHECK  = 8;
    localparam int RAND_PER_OP = 8;
    localparam int CHAIN_LEN   = 40;
    localparam int R0_PAIRS    = 6;
    localparam int ILLEGAL_N   = 20;
    localparam int MIX_CYCLES  = 200;
    localparam int DRAIN       = 4;
    // issue slots of all tests including the drains
    localparam int TOTAL_SLOTS = 2 + IDLE_CHECK + 31 + 2 + 29 * 3 + 5 + 13 * RAND_PER_OP * 2
                               + CHAIN_LEN + R0_PAIRS * 2 + ILLEGAL_N * 2 + MIX_CYCLES
                               + 6 * (DRAIN + 1);

    typedef struct packed {
        logic        illegal;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] due; // edge count at which the result is shown
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        inst_strobe;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        result_valid;
    logic        result_illegal;
    logic [31:0] result_pc;
    logic [4:0]  result_rd;
    logic [31:0] result_data;

    logic [31:0] shadow [32];
    exp_t        exp_q [$];
    logic [15:0] lfsr = 16'd50389;
    logic [31:0] next_pc = 32'h1c00_0000;
    int          edge_cnt = 0;
    int          errors = 0;
    int          checked = 0;
    int          tests = 0;

    la_core_3r la_core_3r_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_strobe    (inst_strobe),
        .pc             (pc),
        .inst           (inst),
        .result_valid   (result_valid),
        .result_illegal (result_illegal),
        .result_pc      (result_pc),
        .result_rd      (result_rd),
        .result_data    (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1); // galois step
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_nz_reg();
        logic [4:0] r;
        r = rand_bits(5);
        while (r == 5'd0) r = rand_bits(5);
        return r;
    endfunction

    function automatic logic [16:0] opcode_at(input int idx);
        case (idx)
            0:  return ADD_OPCODE;
            1:  return SUB_OPCODE;
            2:  return SLT_OPCODE;
            3:  return SLTU_OPCODE;
            4:  return NOR_OPCODE;
            5:  return AND_OPCODE;
            6:  return OR_OPCODE;
            7:  return XOR_OPCODE;
            8:  return SLL_OPCODE;
            9:  return SRL_OPCODE;
            10: return SRA_OPCODE;
            11: return SLLI_OPCODE;
            default: return SRLI_OPCODE;
        endcase
    endfunction

    function automatic logic is_known(input logic [16:0] op);
        for (int i = 0; i < 13; i++) begin
            if (op == opcode_at(i)) return 1'b1;
        end
        return 1'b0;
    endfunction

    // expected result from the instruction rules
    function automatic logic [31:0] ref_alu(input logic [16:0] op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [4:0] ui5);
        case (op)
            ADD_OPCODE:  return a + b;
            SUB_OPCODE:  return a - b;
            SLT_OPCODE:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU_OPCODE: return (a < b) ? 32'd1 : 32'd0;
            NOR_OPCODE:  return ~(a | b);
            AND_OPCODE:  return a & b;
            OR_OPCODE:   return a | b;
            XOR_OPCODE:  return a ^ b;
            SLL_OPCODE:  return a << b[4:0];
            SRL_OPCODE:  return a >> b[4:0];
            SRA_OPCODE:  return $signed(a) >>> b[4:0];
            SLLI_OPCODE: return a << ui5;
            SRLI_OPCODE: return a >> ui5;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic issue(input logic [16:0] op, input logic [4:0] rk, input logic [4:0] rj,
                         input logic [4:0] rd);
        exp_t        e;
        logic        legal;
        logic [31:0] val;
        legal = is_known(op);
        @(negedge clk);
        inst_strobe = 1'b1;
        inst        = {op, rk, rj, rd};
        pc          = next_pc;
        val         = ref_alu(op, shadow[rj], shadow[rk], rk);
        e.illegal   = ~legal;
        e.pc        = next_pc;
        e.rd        = rd;
        e.data      = (legal && rd != 5'd0) ? val : 32'd0;
        e.due       = edge_cnt + 2;
        if (legal && rd != 5'd0) shadow[rd] = val;
        exp_q.push_back(e);
        next_pc = next_pc + 4;
    endtask

    task automatic idle();
        @(negedge clk);
        inst_strobe = 1'b0; // inst keeps its old word
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle();
        while (exp_q.size() != 0 && n < DRAIN) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        errors++;
        $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp_v, act_v);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && (result_valid || result_illegal)) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%0d ns: a result came out with no instruction outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                checked++;
                if (result_illegal !== e.illegal) show_mismatch("result_illegal", e.illegal,
                                                                result_illegal);
                if (result_valid !== ~e.illegal) show_mismatch("result_valid", ~e.illegal,
                                                               result_valid);
                if (result_pc !== e.pc) show_mismatch("result_pc", e.pc, result_pc);
                if (!e.illegal && result_rd !== e.rd) show_mismatch("result_rd", e.rd, result_rd);
                if (result_data !== e.data) show_mismatch("result_data", e.data, result_data);
                if (edge_cnt != e.due) show_mismatch("result edge", e.due, edge_cnt);
            end
        end
    end

    initial begin
        #((TOTAL_SLOTS + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish, %0d results still outstanding", exp_q.size());
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int          err0;
        logic [16:0] op;
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [4:0]  prev2;
        rst_n       = 1'b0;
        inst_strobe = 1'b0;
        pc          = '0;
        inst        = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err0 = errors;
        for (int i = 0; i < IDLE_CHECK; i++) begin
            idle();
            if (result_valid || result_illegal) begin
                errors++;
                $display("%0d ns: result pulse seen with no instruction issued", $time);
            end
        end
        for (int i = 1; i < 32; i++) issue(OR_OPCODE, i, i, i);
        drain();
        finish_test("reset state", err0);

        err0 = errors;
        issue(NOR_OPCODE, 5'd0, 5'd0, 5'd1);    // r1 = all ones
        issue(SRLI_OPCODE, 5'd31, 5'd1, 5'd2);  // r2 = 1
        for (int i = 3; i < 32; i++) begin
            issue(SLLI_OPCODE, rand_bits(5), 5'd1, i);
            issue(XOR_OPCODE, rand_bits(5) % i, i, i);
            issue(ADD_OPCODE, rand_bits(5) % i, i, i);
        end
        issue(SLT_OPCODE, 5'd2, 5'd1, 5'd3);    // -1 < 1 signed
        issue(SLTU_OPCODE, 5'd2, 5'd1, 5'd4);
        issue(SLLI_OPCODE, 5'd31, 5'd1, 5'd5);
        issue(SRA_OPCODE, 5'd2, 5'd5, 5'd6);    // sign fill
        issue(SRL_OPCODE, 5'd2, 5'd5, 5'd7);
        for (int k = 0; k < 13; k++) begin
            for (int i = 0; i < RAND_PER_OP; i++) begin
                issue(opcode_at(k), rand_bits(5), rand_bits(5), rand_nz_reg());
                idle();
            end
        end
        drain();
        finish_test("all instructions", err0);

        err0 = errors;
        prev  = rand_nz_reg();
        prev2 = rand_nz_reg();
        for (int i = 0; i < CHAIN_LEN; i++) begin
            rd = rand_nz_reg();
            issue(opcode_at(rand_bits(4) % 13), prev2, prev, rd);
            prev2 = prev;
            prev  = rd;
        end
        drain();
        finish_test("dependent chain", err0);

        err0 = errors;
        for (int i = 0; i < R0_PAIRS; i++) begin
            issue(opcode_at(rand_bits(4) % 13), rand_bits(5), rand_bits(5), 5'd0);
            issue(OR_OPCODE, 5'd0, 5'd0, rand_nz_reg()); // must not see the r0 result
        end
        drain();
        finish_test("r0 destination", err0);

        err0 = errors;
        for (int i = 0; i < ILLEGAL_N; i++) begin
            op = rand_bits(17);
            while (is_known(op)) op = rand_bits(17);
            rd = rand_nz_reg();
            issue(op, rand_bits(5), rand_bits(5), rd);
            issue(OR_OPCODE, 5'd0, rd, rd);
        end
        drain();
        finish_test("illegal opcodes", err0);

        err0 = errors;
        for (int c = 0; c < MIX_CYCLES; c++) begin
            if (rand_bits(1) == 1'b0) begin
                idle();
            end else if (rand_bits(3) == 3'd0) begin
                op = rand_bits(17);
                while (is_known(op)) op = rand_bits(17);
                issue(op, rand_bits(5), rand_bits(5), rand_bits(5));
            end else begin
                issue(opcode_at(rand_bits(4) % 13), rand_bits(5), rand_bits(5), rand_bits(5));
            end
        end
        drain();
        finish_test("random mix", err0);

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never came out", exp_q.size());
        end
        $display("tests %0d, results checked %0d, errors %0d", tests, checked, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/la_pkg.sv
verilog/id_3r.sv
verilog/reg_file.sv
verilog/alu_exec.sv
verilog/wb_result.sv
verilog/la_core_3r.sv
testbench/tb_la_core_3r.sv
